//--- sources.f
source/rename_pkg.sv
source/dispatch_gate.sv
source/rob.sv
source/free_list.sv
source/rename_map.sv
source/rename_top.sv
bench/rename_sva.sv
bench/rename_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module rename_tb -f sources.f -o rename_sim
	./obj_dir/rename_sim | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/rename_tb.sv
// ==============================
// rename core testbench
// ==============================
module rename_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rename_pkg::*;

    localparam int STIM_CYCLES = 1500;
    localparam int LIMIT_CYCLES = 1800;

    logic                      clock;
    logic                      reset;
    dispatch_req_t [N-1:0]     dispatch_req;
    lane_count_t               dispatch_count;
    complete_t     [N-1:0]     complete;
    lane_count_t               accept_count;
    phys_tag_t     [N-1:0]     dispatch_t;
    rob_entry_t    [N-1:0]     retire_data;
    lane_count_t               retire_count;
    rob_count_t                open_entries;
    free_count_t               free_count;

    // tags accepted but not yet sent on the completion bus
    int pending[$];

    rename_top DUT (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // one cycle: drive at the falling edge, record what was accepted
    task automatic run_cycle(input bit do_dispatch, input bit do_complete);
        int idx;
        dispatch_count = do_dispatch ? lane_count_t'($urandom_range(0, N)) : '0;
        for (int i = 0; i < N; i++) begin
            dispatch_req[i].dest = arch_reg_t'($urandom_range(0, ARCH_REGS - 1));
            complete[i] = '0;
            // pick a distinct outstanding tag per lane
            if (do_complete && pending.size() > 0 && $urandom_range(0, 3) != 0) begin
                idx = $urandom_range(0, pending.size() - 1);
                complete[i].valid = 1'b1;
                complete[i].t = phys_tag_t'(pending[idx]);
                pending.delete(idx);
            end
        end
        #5;
        for (int i = 0; i < N; i++) begin
            if (i < int'(accept_count)) pending.push_back(int'(dispatch_t[i]));
        end
        @(negedge clock);
    endtask

    // watchdog
    initial begin
        #(LIMIT_CYCLES * 20);
        $display("simulation timed out before the drain finished");
        $display("RESULT: FAIL");
        $fatal(1);
    end

    // stop at the first failed assertion
    initial begin
        forever begin
            @(negedge clock);
            if (DUT.u_sva.errors != 0) begin
                $display("assertion failed in the rename checker");
                $display("RESULT: FAIL");
                $fatal(1);
            end
        end
    end

    initial begin
        int waited;
        void'($urandom(72));
        reset = 1'b1;
        dispatch_req = '0;
        dispatch_count = '0;
        complete = '0;
        repeat (2) @(negedge clock);
        reset = 1'b0;
        for (int c = 0; c < STIM_CYCLES; c++) begin
            // every third block of 40 cycles has no completions, so things fill up
            run_cycle(1'b1, ((c / 40) % 3) != 2);
        end
        // drain
        while (pending.size() > 0) run_cycle(1'b0, 1'b1);
        complete = '0;
        waited = 0;
        while (open_entries != rob_count_t'(ROB_DEPTH) && waited < 20) begin
            @(negedge clock);
            waited++;
        end
        if (DUT.u_sva.errors != 0) begin
            $display("assertion failed in the rename checker");
            $display("RESULT: FAIL");
            $fatal(1);
        end else if (open_entries != rob_count_t'(ROB_DEPTH)) begin
            $display("CHECK FAILED open_entries got 0x%0h expected 0x%0h",
                     open_entries, ROB_DEPTH);
            $display("RESULT: FAIL");
            $fatal(1);
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- bench/rename_sva.sv
// ==============================
// rename core checker
// ==============================
module rename_sva (
    input logic                                          clock,
    input logic                                          reset,
    input rename_pkg::lane_count_t                       dispatch_count,
    input rename_pkg::complete_t     [rename_pkg::N-1:0] complete,
    input rename_pkg::lane_count_t                       accept_count,
    input rename_pkg::phys_tag_t     [rename_pkg::N-1:0] dispatch_t,
    input rename_pkg::rob_entry_t    [rename_pkg::N-1:0] retire_data,
    input rename_pkg::lane_count_t                       retire_count,
    input rename_pkg::rob_count_t                        open_entries,
    input rename_pkg::free_count_t                       free_count
);
    timeunit 1ns;
    timeprecision 1ps;
    import rename_pkg::*;

    // count of failed assertions
    int errors = 0;

    // tags in dispatch order, circular
    phys_tag_t [15:0]          order_q;
    int                        wr_ptr;
    int                        rd_ptr;
    // tags seen on the completion bus and not yet retired
    logic      [PHYS_REGS-1:0] done;
    // committed map, moves only on retirement
    phys_tag_t [ARCH_REGS-1:0] arch_map;

    int   exp_accept;
    logic order_ok;
    logic done_ok;
    logic old_ok;

    always_comb begin
        phys_tag_t exp_old;
        exp_old = '0;
        exp_accept = int'(dispatch_count);
        if (int'(open_entries) < exp_accept) exp_accept = int'(open_entries);
        if (int'(free_count) < exp_accept) exp_accept = int'(free_count);
        order_ok = 1'b1;
        done_ok = 1'b1;
        old_ok = 1'b1;
        for (int i = 0; i < N; i++) begin
            if (i < int'(retire_count)) begin
                if (retire_data[i].t != order_q[(rd_ptr + i) % 16]) order_ok = 1'b0;
                if (!done[retire_data[i].t]) done_ok = 1'b0;
                exp_old = arch_map[retire_data[i].dest];
                // lane 1 sees lane 0's write within the same group
                if (i == 1 && retire_data[0].dest == retire_data[1].dest) begin
                    exp_old = retire_data[0].t;
                end
                if (retire_data[i].t_old != exp_old) old_ok = 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= 0;
            rd_ptr <= 0;
            done <= '0;
            for (int k = 0; k < ARCH_REGS; k++) begin
                arch_map[k] <= phys_tag_t'(k);
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                if (i < int'(accept_count)) order_q[(wr_ptr + i) % 16] <= dispatch_t[i];
                if (i < int'(retire_count)) begin
                    done[retire_data[i].t] <= 1'b0;
                    arch_map[retire_data[i].dest] <= retire_data[i].t;
                end
            end
            for (int j = 0; j < N; j++) begin
                if (complete[j].valid) done[complete[j].t] <= 1'b1;
            end
            wr_ptr <= (wr_ptr + int'(accept_count)) % 16;
            rd_ptr <= (rd_ptr + int'(retire_count)) % 16;
        end
    end

    a_reset_state: assert property (@(posedge clock) $fell(reset) |->
        (retire_count == 0 && open_entries == rob_count_t'(ROB_DEPTH) &&
         free_count == free_count_t'(FREE_REGS)))
        else begin
            errors++;
            $error("CHECK FAILED after reset retire_count 0x%0h open_entries 0x%0h free_count 0x%0h",
                   retire_count, open_entries, free_count);
        end

    a_accept: assert property (@(posedge clock) disable iff (reset)
        int'(accept_count) == exp_accept)
        else begin
            errors++;
            $error("CHECK FAILED accept_count got 0x%0h expected 0x%0h",
                   accept_count, exp_accept);
        end

    // free tags and tags held by the ROB add up to the spare registers
    a_conserve: assert property (@(posedge clock) disable iff (reset)
        int'(free_count) + ROB_DEPTH - int'(open_entries) + int'(retire_count) == FREE_REGS)
        else begin
            errors++;
            $error("physical registers lost or duplicated");
        end

    a_in_order: assert property (@(posedge clock) disable iff (reset) order_ok)
        else begin
            errors++;
            $error("retirement out of dispatch order");
        end

    a_completed: assert property (@(posedge clock) disable iff (reset) done_ok)
        else begin
            errors++;
            $error("retired a tag that was not completed");
        end

    a_old_tag: assert property (@(posedge clock) disable iff (reset) old_ok)
        else begin
            errors++;
            $error("retiring t_old does not match map");
        end

endmodule

bind rename_top rename_sva u_sva (
    .clock          (clock),
    .reset          (reset),
    .dispatch_count (dispatch_count),
    .complete       (complete),
    .accept_count   (accept_count),
    .dispatch_t     (dispatch_t),
    .retire_data    (retire_data),
    .retire_count   (retire_count),
    .open_entries   (open_entries),
    .free_count     (free_count)
);

//--- source/rename_top.sv
// ==============================
// rename and retire core
// ==============================
module rename_top (
    input  logic                                          clock,
    input  logic                                          reset,
    input  rename_pkg::dispatch_req_t [rename_pkg::N-1:0] dispatch_req,
    input  rename_pkg::lane_count_t                       dispatch_count,
    input  rename_pkg::complete_t     [rename_pkg::N-1:0] complete,
    output rename_pkg::lane_count_t                       accept_count,
    output rename_pkg::phys_tag_t     [rename_pkg::N-1:0] dispatch_t,
    output rename_pkg::rob_entry_t    [rename_pkg::N-1:0] retire_data,
    output rename_pkg::lane_count_t                       retire_count,
    output rename_pkg::rob_count_t                        open_entries,
    output rename_pkg::free_count_t                       free_count
);
    import rename_pkg::*;

    rob_entry_t [N-1:0] entries;
    phys_tag_t  [N-1:0] alloc_t;
    phys_tag_t  [N-1:0] old_t;
    arch_reg_t  [N-1:0] dest;

    // map table sees destinations only
    for (genvar i = 0; i < N; i++) begin : g_dest
        assign dest[i] = dispatch_req[i].dest;
    end

    // new tags go back to the front end as they are handed out
    assign dispatch_t = alloc_t;

    dispatch_gate u_gate (
        .dispatch_req   (dispatch_req),
        .dispatch_count (dispatch_count),
        .open_entries   (open_entries),
        .free_count     (free_count),
        .alloc_t        (alloc_t),
        .old_t          (old_t),
        .accept_count   (accept_count),
        .entries        (entries)
    );

    rob u_rob (
        .clock         (clock),
        .reset         (reset),
        .wr_data       (entries),
        .num_accept    (accept_count),
        .complete      (complete),
        .retiring_data (retire_data),
        .num_retired   (retire_count),
        .open_entries  (open_entries)
    );

    // retired lanes return their t_old here
    free_list u_free_list (
        .clock         (clock),
        .reset         (reset),
        .pop_count     (accept_count),
        .retiring_data (retire_data),
        .num_retired   (retire_count),
        .alloc_t       (alloc_t),
        .free_count    (free_count)
    );

    rename_map u_map (
        .clock  (clock),
        .reset  (reset),
        .dest   (dest),
        .new_t  (alloc_t),
        .accept (accept_count),
        .old_t  (old_t)
    );

endmodule

//--- source/rename_map.sv
// ==============================
// speculative map table
// ==============================
module rename_map (
    input  logic                                      clock,
    input  logic                                      reset,
    input  rename_pkg::arch_reg_t [rename_pkg::N-1:0] dest,
    input  rename_pkg::phys_tag_t [rename_pkg::N-1:0] new_t,
    input  rename_pkg::lane_count_t                   accept,
    output rename_pkg::phys_tag_t [rename_pkg::N-1:0] old_t
);
    import rename_pkg::*;

    // current physical tag of each architectural register
    phys_tag_t [ARCH_REGS-1:0] map;

    // old tag lookup with bypass inside the dispatch group
    always_comb begin
        for (int i = 0; i < N; i++) begin
            old_t[i] = map[dest[i]];
            // older lanes are accepted whenever lane i is
            // later j overrides earlier, so the nearest older writer wins
            for (int j = 0; j < i; j++) begin
                if (dest[j] == dest[i]) begin
                    old_t[i] = new_t[j];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity mapping, register i lives in tag i
            for (int k = 0; k < ARCH_REGS; k++) begin
                map[k] <= phys_tag_t'(k);
            end
        end else begin
            // lane order, youngest write to a register lands last
            for (int i = 0; i < N; i++) begin
                if (i < int'(accept)) begin
                    map[dest[i]] <= new_t[i];
                end
            end
        end
    end

endmodule

//--- source/free_list.sv
// ==============================
// physical tag free list
// ==============================
module free_list (
    input  logic                                       clock,
    input  logic                                       reset,
    input  rename_pkg::lane_count_t                    pop_count,
    input  rename_pkg::rob_entry_t [rename_pkg::N-1:0] retiring_data,
    input  rename_pkg::lane_count_t                    num_retired,
    output rename_pkg::phys_tag_t  [rename_pkg::N-1:0] alloc_t,
    output rename_pkg::free_count_t                    free_count
);
    import rename_pkg::*;

    phys_tag_t [FREE_REGS-1:0] tags;
    // head is the next tag handed out, tail the next slot to refill
    free_idx_t   head;
    free_idx_t   tail;
    free_count_t count;

    // next N tags, whether or not dispatch takes them
    always_comb begin
        for (int i = 0; i < N; i++) begin
            alloc_t[i] = tags[head + free_idx_t'(i)];
        end
    end

    // this cycle's pushes are not counted until the next edge
    assign free_count = count;

    always_ff @(posedge clock) begin
        if (reset) begin
            // tags above the architectural ones start out free
            for (int k = 0; k < FREE_REGS; k++) begin
                tags[k] <= phys_tag_t'(ARCH_REGS + k);
            end
            head <= '0;
            // queue full, so tail wraps onto head
            tail <= '0;
            count <= free_count_t'(FREE_REGS);
        end else begin
            // a retiring lane gives back the tag its instruction overwrote
            for (int i = 0; i < N; i++) begin
                if (i < int'(num_retired)) begin
                    tags[tail + free_idx_t'(i)] <= retiring_data[i].t_old;
                end
            end
            head <= head + free_idx_t'(pop_count);
            tail <= tail + free_idx_t'(num_retired);
            // pops never exceed count, the gate limits them to free_count
            count <= count - free_count_t'(pop_count) + free_count_t'(num_retired);
        end
    end

endmodule

//--- source/rob.sv
// ==============================
// reorder buffer
// ==============================
module rob (
    input  logic                                       clock,
    input  logic                                       reset,
    input  rename_pkg::rob_entry_t [rename_pkg::N-1:0] wr_data,
    input  rename_pkg::lane_count_t                    num_accept,
    input  rename_pkg::complete_t  [rename_pkg::N-1:0] complete,
    output rename_pkg::rob_entry_t [rename_pkg::N-1:0] retiring_data,
    output rename_pkg::lane_count_t                    num_retired,
    output rename_pkg::rob_count_t                     open_entries
);
    import rename_pkg::*;

    rob_entry_t [ROB_DEPTH-1:0] entries;
    rob_entry_t [ROB_DEPTH-1:0] next_entries;
    // head is the oldest entry, tail the first empty slot
    rob_idx_t   head;
    rob_idx_t   tail;
    rob_count_t count;
    rob_idx_t   slot;
    logic       run;

    // room after this cycle's retirements, so dispatch can reuse them at once
    assign open_entries = rob_count_t'(ROB_DEPTH) - count + rob_count_t'(num_retired);

    // retire the unbroken run of valid and complete entries at the head
    always_comb begin
        retiring_data = '0;
        num_retired = '0;
        run = 1'b1;
        slot = head;
        for (int i = 0; i < N; i++) begin
            slot = head + rob_idx_t'(i);
            if (run && entries[slot].valid && entries[slot].complete) begin
                retiring_data[i] = entries[slot];
                num_retired = num_retired + 1'b1;
            end else begin
                // an incomplete entry blocks everything younger
                run = 1'b0;
            end
        end
    end

    always_comb begin
        next_entries = entries;

        // completion marking, any entry whose tag is on the bus
        for (int k = 0; k < ROB_DEPTH; k++) begin
            for (int j = 0; j < N; j++) begin
                if (entries[k].valid && complete[j].valid &&
                    entries[k].t == complete[j].t) begin
                    next_entries[k].complete = 1'b1;
                end
            end
        end

        // retired slots become empty
        for (int i = 0; i < N; i++) begin
            if (i < int'(num_retired)) begin
                next_entries[head + rob_idx_t'(i)] = '0;
            end
        end

        // accepted lanes go in at the tail, lane 0 first
        for (int i = 0; i < N; i++) begin
            if (i < int'(num_accept)) begin
                next_entries[tail + rob_idx_t'(i)] = wr_data[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entries <= '0;
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            entries <= next_entries;
            // pointers wrap naturally at the power-of-two depth
            head <= head + rob_idx_t'(num_retired);
            tail <= tail + rob_idx_t'(num_accept);
            count <= count - rob_count_t'(num_retired) + rob_count_t'(num_accept);
        end
    end

endmodule

//--- source/dispatch_gate.sv
// ==============================
// dispatch gate
// ==============================
module dispatch_gate (
    input  rename_pkg::dispatch_req_t [rename_pkg::N-1:0] dispatch_req,
    input  rename_pkg::lane_count_t                       dispatch_count,
    input  rename_pkg::rob_count_t                        open_entries,
    input  rename_pkg::free_count_t                       free_count,
    input  rename_pkg::phys_tag_t     [rename_pkg::N-1:0] alloc_t,
    input  rename_pkg::phys_tag_t     [rename_pkg::N-1:0] old_t,
    output rename_pkg::lane_count_t                       accept_count,
    output rename_pkg::rob_entry_t    [rename_pkg::N-1:0] entries
);
    import rename_pkg::*;

    // minimum of requests, ROB room and free tags
    always_comb begin
        accept_count = dispatch_count;
        if (open_entries < rob_count_t'(accept_count)) begin
            accept_count = lane_count_t'(open_entries);
        end
        if (free_count < free_count_t'(accept_count)) begin
            accept_count = lane_count_t'(free_count);
        end
    end

    // ROB entries for every lane, the ROB only writes the accepted ones
    always_comb begin
        for (int i = 0; i < N; i++) begin
            entries[i].valid = 1'b1;
            entries[i].complete = 1'b0;
            entries[i].dest = dispatch_req[i].dest;
            entries[i].t = alloc_t[i];
            entries[i].t_old = old_t[i];
        end
    end

endmodule

//--- source/rename_pkg.sv
// ==============================
// rename core shared types
// ==============================
package rename_pkg;

    // dispatch, retire and completion width
    localparam int N = 2;
    localparam int ROB_DEPTH = 8;
    localparam int ARCH_REGS = 8;
    localparam int PHYS_REGS = 16;
    // registers not held by the architectural state; matches ROB_DEPTH
    localparam int FREE_REGS = PHYS_REGS - ARCH_REGS;

    typedef logic [$clog2(PHYS_REGS)-1:0]   phys_tag_t;
    typedef logic [$clog2(ARCH_REGS)-1:0]   arch_reg_t;
    typedef logic [$clog2(N+1)-1:0]         lane_count_t;
    typedef logic [$clog2(ROB_DEPTH+1)-1:0] rob_count_t;
    typedef logic [$clog2(FREE_REGS+1)-1:0] free_count_t;
    // circular pointers, both depths are powers of two
    typedef logic [$clog2(ROB_DEPTH)-1:0]   rob_idx_t;
    typedef logic [$clog2(FREE_REGS)-1:0]   free_idx_t;

    // one front-end request, destination only
    typedef struct packed {
        arch_reg_t dest;
    } dispatch_req_t;

    typedef struct packed {
        logic      valid;
        logic      complete;
        arch_reg_t dest;
        // new tag and the tag it replaced
        phys_tag_t t;
        phys_tag_t t_old;
    } rob_entry_t;

    // completion bus lane
    typedef struct packed {
        logic      valid;
        phys_tag_t t;
    } complete_t;

endpackage
